// ==== design/rtc_reg_pkg.sv ====
/*
 * Register map of the RTC host port
 * Register indices, control and status bit positions, fixed read values
 */

package rtc_reg_pkg;

    localparam int IDX_W = 7;                    // Width of the index register

    // Register indices behind the data port
    localparam logic [IDX_W-1:0] REG_SEC      = 7'h00;
    localparam logic [IDX_W-1:0] REG_SEC_ALM  = 7'h01;
    localparam logic [IDX_W-1:0] REG_MIN      = 7'h02;
    localparam logic [IDX_W-1:0] REG_MIN_ALM  = 7'h03;
    localparam logic [IDX_W-1:0] REG_HOUR     = 7'h04;
    localparam logic [IDX_W-1:0] REG_HOUR_ALM = 7'h05;
    localparam logic [IDX_W-1:0] REG_DOW      = 7'h06;
    localparam logic [IDX_W-1:0] REG_DOM      = 7'h07;
    localparam logic [IDX_W-1:0] REG_MON      = 7'h08;
    localparam logic [IDX_W-1:0] REG_YEAR     = 7'h09;
    localparam logic [IDX_W-1:0] REG_A        = 7'h0A;
    localparam logic [IDX_W-1:0] REG_B        = 7'h0B;
    localparam logic [IDX_W-1:0] REG_C        = 7'h0C;
    localparam logic [IDX_W-1:0] REG_D        = 7'h0D;

    // Register B bits
    localparam int B_FREEZE     = 7;             // Stops the update cycle
    localparam int B_ALARM_ENA  = 5;
    localparam int B_UPDATE_ENA = 4;
    localparam int B_BINARY     = 2;             // Binary instead of BCD
    localparam int B_24H        = 1;             // Always reads 1

    // Register C bits
    localparam int C_IRQ    = 7;
    localparam int C_ALARM  = 5;
    localparam int C_UPDATE = 4;

    localparam logic [7:0] REG_A_FIXED = 8'h26;  // 32.768 kHz divider, 1024 Hz rate
    localparam logic [7:0] REG_D_VALUE = 8'h80;  // Valid RAM and time

endpackage

// ==== design/rtc_time_pkg.sv ====
/*
 * Time keeping definitions
 * Time byte union, tick and second-cycle constants,
 * calendar step functions for BCD and binary modes
 */

package rtc_time_pkg;

    // One time byte, read as binary or as two BCD digits
    typedef union packed {
        logic [7:0]      bin;
        logic [1:0][3:0] digit;                  // [1] tens, [0] ones
    } time_byte_t;

    localparam int TICK_HZ           = 800;
    localparam int TICKS_PER_SEC     = 800;
    localparam int UPDATE_LEAD_TICKS = 4;       // Ticks before the first update
    localparam int SEC_CNT_W         = 11;

    localparam logic [1:0] ALARM_DONT_CARE = 2'b11;

    // Numeric value of a byte in either mode
    function automatic logic [7:0] to_value(time_byte_t v, logic binary);
        if (binary) begin
            return v.bin;
        end
        return {4'd0, v.digit[1]} * 8'd10 + {4'd0, v.digit[0]};
    endfunction

    // Field has reached its last value
    function automatic logic step_wrap(time_byte_t v, logic [7:0] limit, logic binary);
        return to_value(v, binary) >= limit;
    endfunction

    // Field plus one, BCD carries into the tens digit after 9
    function automatic time_byte_t step_inc(time_byte_t v, logic binary);
        time_byte_t n;
        n.bin = v.bin + 8'd1;
        if (!binary && v.digit[0] >= 4'd9) begin
            n.digit[1] = v.digit[1] + 4'd1;
            n.digit[0] = 4'd0;
        end
        return n;
    endfunction

    // Last day of the month, simplified leap rule
    function automatic logic [7:0] days_in_month(time_byte_t mon, time_byte_t year,
                                                 logic binary);
        logic       leap;
        logic [7:0] days;
        if (binary) begin
            leap = year.bin[1:0] == 2'b00;
        end else begin
            // Decimal year divisible by 4
            leap = year.digit[1][0] ? (year.digit[0][1:0] == 2'b10)
                                    : (year.digit[0][1:0] == 2'b00);
        end
        case (to_value(mon, binary))
            8'd2:                    days = leap ? 8'd29 : 8'd28;
            8'd4, 8'd6, 8'd9, 8'd11: days = 8'd30;
            default:                 days = 8'd31;
        endcase
        return days;
    endfunction

endpackage

// ==== design/rtc_tick_gen.sv ====
/*
 * 800 Hz tick generator
 * Fractional accumulator, exact rate on average for any clock
 */

`timescale 1ns/1ps

module rtc_tick_gen #(
    parameter int CLK_HZ = 50_000_000
) (
    input  logic clk,
    input  logic rst_n,
    output logic tick
);

    localparam int ACC_W = $clog2(CLK_HZ + rtc_time_pkg::TICK_HZ);

    logic [ACC_W-1:0] acc;
    logic [ACC_W-1:0] sum;

    assign sum = acc + ACC_W'(rtc_time_pkg::TICK_HZ);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc  <= '0;
            tick <= 1'b0;
        end else if (sum >= ACC_W'(CLK_HZ)) begin
            acc  <= sum - ACC_W'(CLK_HZ);          // Keep the remainder
            tick <= 1'b1;
        end else begin
            acc  <= sum;
            tick <= 1'b0;
        end
    end

endmodule

// ==== design/rtc_second_fsm.sv ====
/*
 * Once-per-second update cycle
 * Five-state FSM and tick countdown, stopped while frozen
 */

`timescale 1ns/1ps

module rtc_second_fsm (
    input  logic clk,
    input  logic rst_n,
    input  logic tick,
    input  logic freeze,
    output logic second_start,
    output logic update_in_progress
);

    localparam int CW = rtc_time_pkg::SEC_CNT_W;

    localparam logic [CW-1:0] LEAD   = CW'(rtc_time_pkg::UPDATE_LEAD_TICKS);
    localparam logic [CW-1:0] RELOAD = CW'(rtc_time_pkg::TICKS_PER_SEC - 1);

    localparam logic [2:0] ST_UPDATE_START   = 3'd0;
    localparam logic [2:0] ST_UPDATE_IN_PROG = 3'd1;
    localparam logic [2:0] ST_SECOND_START   = 3'd2;
    localparam logic [2:0] ST_SECOND_IN_PROG = 3'd3;
    localparam logic [2:0] ST_STOPPED        = 3'd4;

    logic [2:0]    state;
    logic [CW-1:0] cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_UPDATE_START;
        end else if (freeze) begin
            state <= ST_STOPPED;
        end else begin
            case (state)
                ST_STOPPED:        state <= ST_UPDATE_START;  // Restart after freeze
                ST_UPDATE_START:   state <= ST_UPDATE_IN_PROG;
                ST_UPDATE_IN_PROG: if (cnt == '0) state <= ST_SECOND_START;
                ST_SECOND_START:   state <= ST_SECOND_IN_PROG;
                ST_SECOND_IN_PROG: if (cnt == CW'(1)) state <= ST_UPDATE_START;
                default:           state <= ST_UPDATE_START;
            endcase
        end
    end

    // Reload happens on a tick so one cycle spans exactly TICKS_PER_SEC ticks
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= LEAD;
        end else if (freeze) begin
            cnt <= LEAD;
        end else if (tick) begin
            cnt <= (cnt == '0) ? RELOAD : cnt - CW'(1);
        end
    end

    assign second_start       = state == ST_SECOND_START;
    assign update_in_progress = (state == ST_UPDATE_IN_PROG) || second_start;

endmodule

// ==== design/rtc_timekeeper.sv ====
/*
 * Time and alarm registers
 * Host writes, once-per-second carry chain, alarm compare
 */

`timescale 1ns/1ps

module rtc_timekeeper (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         second_start,
    input  logic                         binary_mode,
    input  logic                         wr_en,
    input  logic [rtc_reg_pkg::IDX_W-1:0] wr_index,
    input  logic [7:0]                   wr_data,
    output rtc_time_pkg::time_byte_t     sec,
    output rtc_time_pkg::time_byte_t     min,
    output rtc_time_pkg::time_byte_t     hour,
    output rtc_time_pkg::time_byte_t     dow,
    output rtc_time_pkg::time_byte_t     dom,
    output rtc_time_pkg::time_byte_t     mon,
    output rtc_time_pkg::time_byte_t     year,
    output rtc_time_pkg::time_byte_t     sec_alm,
    output rtc_time_pkg::time_byte_t     min_alm,
    output rtc_time_pkg::time_byte_t     hour_alm,
    output logic                         alarm_hit
);

    rtc_time_pkg::time_byte_t next_sec, next_min, next_hour;
    rtc_time_pkg::time_byte_t next_dow, next_dom, next_mon, next_year;
    logic wrap_sec, wrap_min, wrap_hour, wrap_dow, wrap_dom, wrap_mon, wrap_year;
    logic upd_min, upd_hour, upd_day, upd_mon, upd_year;
    logic hit_sec, hit_min, hit_hour;

    ////////////////////////////////////////////////////////////////////////////
    // Carry chain

    assign wrap_sec  = rtc_time_pkg::step_wrap(sec, 8'd59, binary_mode);
    assign wrap_min  = rtc_time_pkg::step_wrap(min, 8'd59, binary_mode);
    assign wrap_hour = rtc_time_pkg::step_wrap(hour, 8'd23, binary_mode);   // 24-hour only
    assign wrap_dow  = rtc_time_pkg::step_wrap(dow, 8'd7, binary_mode);
    assign wrap_dom  = rtc_time_pkg::step_wrap(dom,
                           rtc_time_pkg::days_in_month(mon, year, binary_mode), binary_mode);
    assign wrap_mon  = rtc_time_pkg::step_wrap(mon, 8'd12, binary_mode);
    assign wrap_year = rtc_time_pkg::step_wrap(year, 8'd99, binary_mode);

    assign next_sec  = wrap_sec  ? 8'd0 : rtc_time_pkg::step_inc(sec, binary_mode);
    assign next_min  = wrap_min  ? 8'd0 : rtc_time_pkg::step_inc(min, binary_mode);
    assign next_hour = wrap_hour ? 8'd0 : rtc_time_pkg::step_inc(hour, binary_mode);
    assign next_dow  = wrap_dow  ? 8'd1 : rtc_time_pkg::step_inc(dow, binary_mode);
    assign next_dom  = wrap_dom  ? 8'd1 : rtc_time_pkg::step_inc(dom, binary_mode);
    assign next_mon  = wrap_mon  ? 8'd1 : rtc_time_pkg::step_inc(mon, binary_mode);
    assign next_year = wrap_year ? 8'd0 : rtc_time_pkg::step_inc(year, binary_mode);

    assign upd_min  = second_start && wrap_sec;
    assign upd_hour = upd_min  && wrap_min;
    assign upd_day  = upd_hour && wrap_hour;
    assign upd_mon  = upd_day  && wrap_dom;
    assign upd_year = upd_mon  && wrap_mon;

    // Host write in the same cycle wins over the update
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            {sec, min, hour, dow, dom, mon, year} <= '0;
            {sec_alm, min_alm, hour_alm}          <= '0;
        end else begin
            if (second_start) sec  <= next_sec;
            if (upd_min)      min  <= next_min;
            if (upd_hour)     hour <= next_hour;
            if (upd_day)      dow  <= next_dow;
            if (upd_day)      dom  <= next_dom;
            if (upd_mon)      mon  <= next_mon;
            if (upd_year)     year <= next_year;
            if (wr_en) begin
                case (wr_index)
                    rtc_reg_pkg::REG_SEC:      sec      <= wr_data;
                    rtc_reg_pkg::REG_SEC_ALM:  sec_alm  <= wr_data;
                    rtc_reg_pkg::REG_MIN:      min      <= wr_data;
                    rtc_reg_pkg::REG_MIN_ALM:  min_alm  <= wr_data;
                    rtc_reg_pkg::REG_HOUR:     hour     <= wr_data;
                    rtc_reg_pkg::REG_HOUR_ALM: hour_alm <= wr_data;
                    rtc_reg_pkg::REG_DOW:      dow      <= wr_data;
                    rtc_reg_pkg::REG_DOM:      dom      <= wr_data;
                    rtc_reg_pkg::REG_MON:      mon      <= wr_data;
                    rtc_reg_pkg::REG_YEAR:     year     <= wr_data;
                    default: ;                                 // Not a time register
                endcase
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Alarm compare against the time this update produces

    assign hit_sec  = (sec_alm.bin[7:6] == rtc_time_pkg::ALARM_DONT_CARE) ||
                      (sec_alm.bin == next_sec.bin);
    assign hit_min  = (min_alm.bin[7:6] == rtc_time_pkg::ALARM_DONT_CARE) ||
                      (min_alm.bin == (upd_min ? next_min.bin : min.bin));
    assign hit_hour = (hour_alm.bin[7:6] == rtc_time_pkg::ALARM_DONT_CARE) ||
                      (hour_alm.bin == (upd_hour ? next_hour.bin : hour.bin));

    assign alarm_hit = second_start && hit_sec && hit_min && hit_hour;

endmodule

// ==== design/rtc_host_regs.sv ====
/*
 * Host side of the RTC
 * Index register, register B, update and alarm flags, irq,
 * registered read mux over the data port
 */

`timescale 1ns/1ps

module rtc_host_regs (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          io_address,
    input  logic                          io_read,
    input  logic                          io_write,
    input  logic [7:0]                    io_writedata,
    output logic [7:0]                    io_readdata,
    output logic                          irq,
    input  logic                          update_in_progress,
    input  logic                          second_start,
    input  logic                          alarm_hit,
    input  rtc_time_pkg::time_byte_t      sec,
    input  rtc_time_pkg::time_byte_t      min,
    input  rtc_time_pkg::time_byte_t      hour,
    input  rtc_time_pkg::time_byte_t      dow,
    input  rtc_time_pkg::time_byte_t      dom,
    input  rtc_time_pkg::time_byte_t      mon,
    input  rtc_time_pkg::time_byte_t      year,
    input  rtc_time_pkg::time_byte_t      sec_alm,
    input  rtc_time_pkg::time_byte_t      min_alm,
    input  rtc_time_pkg::time_byte_t      hour_alm,
    output logic                          freeze,
    output logic                          binary_mode,
    output logic                          wr_en,
    output logic [rtc_reg_pkg::IDX_W-1:0] wr_index,
    output logic [7:0]                    wr_data
);

    logic [rtc_reg_pkg::IDX_W-1:0] index;
    logic       alarm_ena, update_ena;
    logic       alarm_flag, update_flag;
    logic       read_d, read_c;
    logic [7:0] reg_b, reg_c, read_mux;

    assign wr_en    = io_write && io_address;          // Data port write
    assign wr_index = index;
    assign wr_data  = io_writedata;

    assign read_c = io_read && !read_d && io_address && (index == rtc_reg_pkg::REG_C);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            index       <= '0;
            read_d      <= 1'b0;
            freeze      <= 1'b0;
            alarm_ena   <= 1'b0;
            update_ena  <= 1'b0;
            binary_mode <= 1'b0;
        end else begin
            read_d <= io_read;                         // First cycle of a read pulse
            if (io_write && !io_address) begin
                index <= io_writedata[rtc_reg_pkg::IDX_W-1:0];
            end
            if (wr_en && index == rtc_reg_pkg::REG_B) begin
                freeze      <= io_writedata[rtc_reg_pkg::B_FREEZE];
                alarm_ena   <= io_writedata[rtc_reg_pkg::B_ALARM_ENA];
                update_ena  <= io_writedata[rtc_reg_pkg::B_UPDATE_ENA] &&
                               !io_writedata[rtc_reg_pkg::B_FREEZE];
                binary_mode <= io_writedata[rtc_reg_pkg::B_BINARY];
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Flags and interrupt, a read of C clears them all

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            update_flag <= 1'b0;
            alarm_flag  <= 1'b0;
            irq         <= 1'b0;
        end else if (read_c) begin
            update_flag <= 1'b0;
            alarm_flag  <= 1'b0;
            irq         <= 1'b0;
        end else begin
            if (second_start) update_flag <= 1'b1;
            if (alarm_hit)    alarm_flag  <= 1'b1;
            if ((alarm_ena && alarm_flag) || (update_ena && update_flag)) irq <= 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Read path

    always_comb begin
        reg_b = 8'h00;
        reg_b[rtc_reg_pkg::B_FREEZE]     = freeze;
        reg_b[rtc_reg_pkg::B_ALARM_ENA]  = alarm_ena;
        reg_b[rtc_reg_pkg::B_UPDATE_ENA] = update_ena;
        reg_b[rtc_reg_pkg::B_BINARY]     = binary_mode;
        reg_b[rtc_reg_pkg::B_24H]        = 1'b1;
        reg_c = 8'h00;
        reg_c[rtc_reg_pkg::C_IRQ]        = irq;
        reg_c[rtc_reg_pkg::C_ALARM]      = alarm_flag;
        reg_c[rtc_reg_pkg::C_UPDATE]     = update_flag;
    end

    always_comb begin
        read_mux = 8'h00;                              // Unmapped index
        if (!io_address) begin
            read_mux = 8'hFF;
        end else begin
            case (index)
                rtc_reg_pkg::REG_SEC:      read_mux = sec.bin;
                rtc_reg_pkg::REG_SEC_ALM:  read_mux = sec_alm.bin;
                rtc_reg_pkg::REG_MIN:      read_mux = min.bin;
                rtc_reg_pkg::REG_MIN_ALM:  read_mux = min_alm.bin;
                rtc_reg_pkg::REG_HOUR:     read_mux = hour.bin;
                rtc_reg_pkg::REG_HOUR_ALM: read_mux = hour_alm.bin;
                rtc_reg_pkg::REG_DOW:      read_mux = dow.bin;
                rtc_reg_pkg::REG_DOM:      read_mux = dom.bin;
                rtc_reg_pkg::REG_MON:      read_mux = mon.bin;
                rtc_reg_pkg::REG_YEAR:     read_mux = year.bin;
                rtc_reg_pkg::REG_A:        read_mux = {update_in_progress,
                                                       rtc_reg_pkg::REG_A_FIXED[6:0]};
                rtc_reg_pkg::REG_B:        read_mux = reg_b;
                rtc_reg_pkg::REG_C:        read_mux = reg_c;
                rtc_reg_pkg::REG_D:        read_mux = rtc_reg_pkg::REG_D_VALUE;
                default:                   read_mux = 8'h00;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) io_readdata <= 8'h00;
        else        io_readdata <= read_mux;
    end

endmodule

// ==== design/rtc_top.sv ====
/*
 * Real-time clock top level
 * Tick generator, second FSM, timekeeper and host registers
 */

`timescale 1ns/1ps

module rtc_top #(
    parameter int CLK_HZ = 50_000_000
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       io_address,
    input  logic       io_read,
    input  logic       io_write,
    input  logic [7:0] io_writedata,
    output logic [7:0] io_readdata,
    output logic       irq
);

    logic tick, freeze, binary_mode;
    logic second_start, update_in_progress, alarm_hit;
    logic wr_en;
    logic [rtc_reg_pkg::IDX_W-1:0] wr_index;
    logic [7:0] wr_data;
    rtc_time_pkg::time_byte_t sec, min, hour, dow, dom, mon, year;
    rtc_time_pkg::time_byte_t sec_alm, min_alm, hour_alm;

    rtc_tick_gen #(.CLK_HZ(CLK_HZ)) u_tick_gen (.clk, .rst_n, .tick);

    rtc_second_fsm u_second_fsm (.clk, .rst_n, .tick, .freeze, .second_start,
                                 .update_in_progress);

    rtc_timekeeper u_timekeeper (.clk, .rst_n, .second_start, .binary_mode, .wr_en,
                                 .wr_index, .wr_data, .sec, .min, .hour, .dow, .dom,
                                 .mon, .year, .sec_alm, .min_alm, .hour_alm, .alarm_hit);

    rtc_host_regs u_host_regs (.clk, .rst_n, .io_address, .io_read, .io_write,
                               .io_writedata, .io_readdata, .irq, .update_in_progress,
                               .second_start, .alarm_hit, .sec, .min, .hour, .dow, .dom,
                               .mon, .year, .sec_alm, .min_alm, .hour_alm, .freeze,
                               .binary_mode, .wr_en, .wr_index, .wr_data);

endmodule

// ==== bench/rtc_tb.sv ====
/*
 * Testbench for the RTC top level
 * Clock and reset, host port tasks, table of update cases,
 * value checker and watchdog
 */

`timescale 1ns/1ps

module rtc_tb;

    localparam int CLK_HZ   = 1600;                            // Two clocks per tick
    localparam int NROWS    = 10;
    localparam int WATCH_NS = (NROWS * 2 * CLK_HZ + 5000) * 10;  // Two seconds per row

    logic       clk = 1'b0;
    logic       rst_n;
    logic       io_address;
    logic       io_read;
    logic       io_write;
    logic [7:0] io_writedata;
    logic [7:0] io_readdata;
    logic       irq;

    int errors = 0;
    int checks = 0;

    // Update cases, times as {hh,mm,ss} and dates as {dow,dom,mon,year}
    logic        row_bin [NROWS];
    logic [7:0]  row_ena [NROWS];
    logic [23:0] row_t0  [NROWS];
    logic [31:0] row_d0  [NROWS];
    logic [23:0] row_alm [NROWS];
    logic [23:0] row_t1  [NROWS];
    logic [31:0] row_d1  [NROWS];
    logic [7:0]  row_c   [NROWS];
    logic        row_irq [NROWS];

    rtc_top #(.CLK_HZ(CLK_HZ)) u_dut (
        .clk, .rst_n, .io_address, .io_read, .io_write, .io_writedata, .io_readdata, .irq
    );

    always #5 clk = ~clk;

    task automatic check(input string name, input logic [7:0] expected,
                         input logic [7:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("MISMATCH at %0t ns: %s expected 0x%02h, got 0x%02h",
                     $time, name, expected, actual);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Host port access

    task automatic write_port(input logic addr, input logic [7:0] data);
        @(posedge clk);
        io_address   <= addr;
        io_writedata <= data;
        io_write     <= 1'b1;
        @(posedge clk);
        io_write     <= 1'b0;
    endtask

    // Read data is registered, taken at the falling edge after capture
    task automatic read_port(input logic addr, output logic [7:0] data);
        @(posedge clk);
        io_address <= addr;
        io_read    <= 1'b1;
        @(posedge clk);
        io_read    <= 1'b0;
        @(negedge clk);
        data = io_readdata;
    endtask

    task automatic read_reg(input logic [6:0] idx, output logic [7:0] data);
        write_port(1'b0, {1'b0, idx});
        read_port(1'b1, data);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Case table

    task automatic set_row(input int n, input logic bin, input logic [7:0] ena,
                           input logic [23:0] t0, input logic [31:0] d0,
                           input logic [23:0] alm, input logic [23:0] t1,
                           input logic [31:0] d1, input logic [7:0] c_exp,
                           input logic irq_exp);
        row_bin[n] = bin;
        row_ena[n] = ena;
        row_t0[n]  = t0;
        row_d0[n]  = d0;
        row_alm[n] = alm;
        row_t1[n]  = t1;
        row_d1[n]  = d1;
        row_c[n]   = c_exp;
        row_irq[n] = irq_exp;
    endtask

    task automatic load_table();
        //   n  bin ena  time0     date0       alarm     time1     date1       C    irq
        set_row(0, 0, 'h10, 'h235959, 'h07311299, 'h123456, 'h000000, 'h01010100, 'h90, 1);
        set_row(1, 0, 'h00, 'h235959, 'h02280223, 'h123456, 'h000000, 'h03010323, 'h10, 0);
        set_row(2, 0, 'h30, 'h235959, 'h03280224, 'h123456, 'h000000, 'h04290224, 'h90, 1);
        set_row(3, 0, 'h30, 'h095959, 'h05150705, 'h100000, 'h100000, 'h05150705, 'hB0, 1);
        set_row(4, 0, 'h20, 'h142538, 'h03101108, 'hC0FF39, 'h142539, 'h03101108, 'hB0, 1);
        set_row(5, 0, 'h20, 'h142538, 'h03101108, 'h142538, 'h142539, 'h03101108, 'h10, 0);
        set_row(6, 1, 'h10, 'h173B3B, 'h071F0C63, 'h123456, 'h000000, 'h01010100, 'h90, 1);
        set_row(7, 1, 'h30, 'h173B3B, 'h041E0415, 'h000000, 'h000000, 'h05010515, 'hB0, 1);
        set_row(8, 1, 'h00, 'h173B3B, 'h061C0218, 'h123456, 'h000000, 'h071D0218, 'h10, 0);
        set_row(9, 1, 'h10, 'h173B3B, 'h071C0217, 'h123456, 'h000000, 'h01010317, 'h90, 1);
    endtask

    // Byte of a row at a register index
    function automatic logic [7:0] row_byte(logic [23:0] t, logic [31:0] d,
                                            logic [23:0] alm, logic [6:0] idx);
        case (idx)
            rtc_reg_pkg::REG_SEC:      return t[7:0];
            rtc_reg_pkg::REG_SEC_ALM:  return alm[7:0];
            rtc_reg_pkg::REG_MIN:      return t[15:8];
            rtc_reg_pkg::REG_MIN_ALM:  return alm[15:8];
            rtc_reg_pkg::REG_HOUR:     return t[23:16];
            rtc_reg_pkg::REG_HOUR_ALM: return alm[23:16];
            rtc_reg_pkg::REG_DOW:      return d[31:24];
            rtc_reg_pkg::REG_DOM:      return d[23:16];
            rtc_reg_pkg::REG_MON:      return d[15:8];
            default:                   return d[7:0];
        endcase
    endfunction

    function automatic string field_name(int n, logic [6:0] idx);
        string names [10] = '{"sec", "sec_alm", "min", "min_alm", "hour", "hour_alm",
                              "dow", "dom", "mon", "year"};
        return $sformatf("row %0d %s", n, names[idx]);
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // One update cycle per row

    // UIP in register A must rise and fall again
    task automatic wait_update();
        logic [7:0] a;
        logic       seen;
        seen = 1'b0;
        a    = 8'h00;
        write_port(1'b0, {1'b0, rtc_reg_pkg::REG_A});
        for (int polls = 0; polls < 200; polls++) begin
            read_port(1'b1, a);
            if (a[7]) seen = 1'b1;
            else if (seen) break;
        end
        if (!seen || a[7]) begin
            errors++;
            $display("Update cycle did not complete after freeze was released");
        end
    endtask

    task automatic run_row(input int n);
        logic [7:0] bin_bit;
        logic [7:0] data;
        bin_bit = {5'd0, row_bin[n], 2'd0};
        write_port(1'b0, {1'b0, rtc_reg_pkg::REG_B});
        write_port(1'b1, 8'h90 | bin_bit);                 // Freeze with update enable
        read_reg(rtc_reg_pkg::REG_C, data);                // Drop stale flags
        for (int i = 0; i < 10; i++) begin
            write_port(1'b0, 8'(i));
            write_port(1'b1, row_byte(row_t0[n], row_d0[n], row_alm[n], 7'(i)));
        end
        repeat (CLK_HZ + 100) @(posedge clk);              // Over one second frozen
        read_reg(rtc_reg_pkg::REG_C, data);
        check($sformatf("row %0d reg_c frozen", n), 8'h00, data);
        read_reg(rtc_reg_pkg::REG_B, data);
        check($sformatf("row %0d reg_b frozen", n), 8'h82 | bin_bit, data);
        for (int i = 0; i < 10; i++) begin
            read_reg(7'(i), data);
            check(field_name(n, 7'(i)), row_byte(row_t0[n], row_d0[n], row_alm[n], 7'(i)),
                  data);
        end
        write_port(1'b0, {1'b0, rtc_reg_pkg::REG_B});
        write_port(1'b1, row_ena[n] | bin_bit);            // Release freeze
        wait_update();
        @(negedge clk);
        check($sformatf("row %0d irq", n), {7'd0, row_irq[n]}, {7'd0, irq});
        read_reg(rtc_reg_pkg::REG_C, data);
        check($sformatf("row %0d reg_c", n), row_c[n], data);
        read_port(1'b1, data);
        check($sformatf("row %0d reg_c cleared", n), 8'h00, data);
        @(negedge clk);
        check($sformatf("row %0d irq cleared", n), 8'h00, {7'd0, irq});
        read_reg(rtc_reg_pkg::REG_B, data);
        check($sformatf("row %0d reg_b", n), row_ena[n] | 8'h02 | bin_bit, data);
        for (int i = 0; i < 10; i++) begin
            read_reg(7'(i), data);
            check(field_name(n, 7'(i)), row_byte(row_t1[n], row_d1[n], row_alm[n], 7'(i)),
                  data);
        end
    endtask

    initial begin
        logic [7:0] data;
        rst_n        = 1'b0;
        io_address   = 1'b0;
        io_read      = 1'b0;
        io_write     = 1'b0;
        io_writedata = 8'h00;
        load_table();
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        // C first, before the lead ticks run out
        read_reg(rtc_reg_pkg::REG_C, data);
        check("reset reg_c", 8'h00, data);
        check("reset irq", 8'h00, {7'd0, irq});
        read_reg(rtc_reg_pkg::REG_B, data);
        check("reset reg_b", 8'h02, data);
        read_reg(rtc_reg_pkg::REG_D, data);
        check("reset reg_d", 8'h80, data);
        read_reg(rtc_reg_pkg::REG_A, data);
        check("reset reg_a", 8'h26, data & 8'h7F);
        read_port(1'b0, data);
        check("index port", 8'hFF, data);
        read_reg(7'h0E, data);
        check("unmapped index", 8'h00, data);

        for (int n = 0; n < NROWS; n++) begin
            run_row(n);
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    initial begin
        #(WATCH_NS);
        $display("Watchdog expired after %0d ns with %0d errors", WATCH_NS, errors);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

// ==== compile.f ====
design/rtc_reg_pkg.sv
design/rtc_time_pkg.sv
design/rtc_tick_gen.sv
design/rtc_second_fsm.sv
design/rtc_timekeeper.sv
design/rtc_host_regs.sv
design/rtc_top.sv
bench/rtc_tb.sv

// ==== Bender.yml ====
package:
  name: rtc

sources:
  - design/rtc_reg_pkg.sv
  - design/rtc_time_pkg.sv
  - design/rtc_tick_gen.sv
  - design/rtc_second_fsm.sv
  - design/rtc_timekeeper.sv
  - design/rtc_host_regs.sv
  - design/rtc_top.sv
  - target: test
    files:
      - bench/rtc_tb.sv
